//--- source/soc_defines.svh
// soc slice sizing
// shared widths and depths for the memory path and the console UART

`ifndef SOC_DEFINES_SVH
`define SOC_DEFINES_SVH

// word address width into the SRAM
`define SOC_ADDR_W    8
// data word and byte enable widths
`define SOC_DATA_W    32
`define SOC_BE_W      4

// SRAM depth in words
`define SOC_MEM_WORDS 256

// clock cycles per UART bit
`define SOC_UART_DIV  16

// console job length in bytes
`define SOC_LEN_W     10

`endif

//--- source/soc_pkg.sv
// soc slice types
// memory request and response words plus the console print job

`include "soc_defines.svh"

package soc_pkg;

  //////////////////////////////
  // memory port
  //////////////////////////////

  // one access toward the SRAM, 45 bits
  typedef struct packed {
    logic [`SOC_ADDR_W-1:0] addr;
    logic                   we;
    logic [`SOC_DATA_W-1:0] wdata;
    logic [`SOC_BE_W-1:0]   be;
  } mem_req_t;

  // read data, one cycle after the access
  typedef struct packed {
    logic [`SOC_DATA_W-1:0] rdata;
  } mem_rsp_t;

  //////////////////////////////
  // console
  //////////////////////////////

  // base word and byte count of a print job
  typedef struct packed {
    logic [`SOC_ADDR_W-1:0] base;
    logic [`SOC_LEN_W-1:0]  len;
  } console_cmd_t;

endpackage

//--- source/mem_arbiter.sv
// memory arbiter
// round-robin between two peer masters on one single-port SRAM,
// response routed back to the owner of the access one cycle later

`timescale 1ns/1ps

module mem_arbiter (
  input  logic              clk_i,
  input  logic              rst_n_i,

  // master 0, host port
  input  logic              m0_req_i,
  input  soc_pkg::mem_req_t m0_pkt_i,
  output logic              m0_gnt_o,
  output logic              m0_rsp_valid_o,
  output soc_pkg::mem_rsp_t m0_rsp_o,

  // master 1, console engine
  input  logic              m1_req_i,
  input  soc_pkg::mem_req_t m1_pkt_i,
  output logic              m1_gnt_o,
  output logic              m1_rsp_valid_o,
  output soc_pkg::mem_rsp_t m1_rsp_o,

  // toward the SRAM
  output logic              mem_en_o,
  output soc_pkg::mem_req_t mem_pkt_o,
  input  soc_pkg::mem_rsp_t mem_rsp_i
);

  // high when master 1 had the last grant
  logic last_q;
  // access in flight and who owns it
  logic valid_q;
  logic owner_q;

  //////////////////////////////
  // grant
  //////////////////////////////

  // lone requester wins at once, otherwise the one not served last
  assign m0_gnt_o = m0_req_i & (~m1_req_i | last_q);
  assign m1_gnt_o = m1_req_i & (~m0_req_i | ~last_q);

  assign mem_en_o  = m0_gnt_o | m1_gnt_o;
  assign mem_pkt_o = m1_gnt_o ? m1_pkt_i : m0_pkt_i;

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      last_q  <= 1'b1;
      valid_q <= 1'b0;
      owner_q <= 1'b0;
    end else begin
      valid_q <= mem_en_o;
      if (mem_en_o) begin
        last_q  <= m1_gnt_o;
        owner_q <= m1_gnt_o;
      end
    end
  end

  //////////////////////////////
  // response steering
  //////////////////////////////

  assign m0_rsp_valid_o = valid_q & ~owner_q;
  assign m1_rsp_valid_o = valid_q & owner_q;

  // rdata only shows up at its owner
  assign m0_rsp_o = m0_rsp_valid_o ? mem_rsp_i : '0;
  assign m1_rsp_o = m1_rsp_valid_o ? mem_rsp_i : '0;

endmodule

//--- source/sram_bank.sv
// sram bank
// single-port word memory with byte enables, read data one cycle later

`timescale 1ns/1ps

`include "soc_defines.svh"

module sram_bank (
  input  logic              clk_i,
  input  logic              mem_en_i,
  input  soc_pkg::mem_req_t mem_pkt_i,
  output soc_pkg::mem_rsp_t mem_rsp_o
);

  logic [`SOC_DATA_W-1:0] mem_q [`SOC_MEM_WORDS];
  logic [`SOC_DATA_W-1:0] rdata_q;

  always_ff @(posedge clk_i) begin
    if (mem_en_i) begin
      if (mem_pkt_i.we) begin
        // merge only the enabled bytes
        for (int i = 0; i < `SOC_BE_W; i++) begin
          if (mem_pkt_i.be[i]) begin
            mem_q[mem_pkt_i.addr][i*8 +: 8] <= mem_pkt_i.wdata[i*8 +: 8];
          end
        end
      end else begin
        rdata_q <= mem_q[mem_pkt_i.addr];
      end
    end
  end

  assign mem_rsp_o.rdata = rdata_q;

endmodule

//--- source/console_dma.sv
// console DMA engine
// reads a byte string from SRAM one word at a time and
// hands the bytes, lowest first, to the UART transmitter

`timescale 1ns/1ps

`include "soc_defines.svh"

module console_dma (
  input  logic                  clk_i,
  input  logic                  rst_n_i,

  // job control
  input  logic                  start_i,
  input  soc_pkg::console_cmd_t cmd_i,
  output logic                  busy_o,

  // memory master
  output logic                  req_o,
  output soc_pkg::mem_req_t     pkt_o,
  input  logic                  gnt_i,
  input  logic                  rsp_valid_i,
  input  soc_pkg::mem_rsp_t     rsp_i,

  // byte stream to the transmitter
  output logic                  tx_valid_o,
  output logic [7:0]            tx_byte_o,
  input  logic                  tx_ready_i
);

  typedef enum logic [2:0] {
    ST_IDLE,
    ST_FETCH,
    ST_WAIT_DATA,
    ST_SEND,
    ST_DRAIN
  } state_e;

  state_e                 state_q;
  logic [`SOC_ADDR_W-1:0] addr_q;
  logic [`SOC_LEN_W-1:0]  remain_q;
  logic [1:0]             byte_idx_q;
  logic [`SOC_DATA_W-1:0] word_q;

  //////////////////////////////
  // outputs
  //////////////////////////////

  assign busy_o = (state_q != ST_IDLE);
  assign req_o  = (state_q == ST_FETCH);

  // read-only master
  assign pkt_o.addr  = addr_q;
  assign pkt_o.we    = 1'b0;
  assign pkt_o.wdata = '0;
  assign pkt_o.be    = '1;

  assign tx_valid_o = (state_q == ST_SEND);
  assign tx_byte_o  = word_q[7:0];

  //////////////////////////////
  // job FSM
  //////////////////////////////

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      state_q    <= ST_IDLE;
      addr_q     <= '0;
      remain_q   <= '0;
      byte_idx_q <= '0;
    end else begin
      case (state_q)
        ST_IDLE: begin
          if (start_i) begin
            addr_q   <= cmd_i.base;
            remain_q <= cmd_i.len;
            // empty job only shows busy for one cycle
            state_q  <= (cmd_i.len == '0) ? ST_DRAIN : ST_FETCH;
          end
        end
        ST_FETCH: begin
          if (gnt_i) begin
            addr_q  <= addr_q + 1'b1;
            state_q <= ST_WAIT_DATA;
          end
        end
        ST_WAIT_DATA: begin
          if (rsp_valid_i) begin
            byte_idx_q <= '0;
            state_q    <= ST_SEND;
          end
        end
        ST_SEND: begin
          if (tx_ready_i) begin
            remain_q   <= remain_q - 1'b1;
            byte_idx_q <= byte_idx_q + 1'b1;
            if (remain_q == `SOC_LEN_W'(1)) begin
              state_q <= ST_DRAIN;
            end else if (byte_idx_q == 2'd3) begin
              // word used up, go get the next one
              state_q <= ST_FETCH;
            end
          end
        end
        ST_DRAIN: begin
          // transmitter back to idle means the last stop bit is out
          if (tx_ready_i) begin
            state_q <= ST_IDLE;
          end
        end
        default: state_q <= ST_IDLE;
      endcase
    end
  end

  // word buffer, shifted down one byte per accepted byte
  always_ff @(posedge clk_i) begin
    if (state_q == ST_WAIT_DATA && rsp_valid_i) begin
      word_q <= rsp_i.rdata;
    end else if (state_q == ST_SEND && tx_ready_i) begin
      word_q <= {8'h00, word_q[`SOC_DATA_W-1:8]};
    end
  end

endmodule

//--- source/uart_tx.sv
// uart transmitter
// 8N1 serializer, one byte per frame, LSB first

`timescale 1ns/1ps

`include "soc_defines.svh"

module uart_tx (
  input  logic       clk_i,
  input  logic       rst_n_i,
  input  logic       tx_valid_i,
  input  logic [7:0] tx_byte_i,
  output logic       tx_ready_o,
  output logic       uart_tx_o
);

  localparam int DIV_W = $clog2(`SOC_UART_DIV);

  logic             busy_q;
  logic [DIV_W-1:0] div_cnt_q;
  logic [3:0]       bit_idx_q;
  // stop, data, start; bit 0 drives the line
  logic [9:0]       frame_q;

  assign tx_ready_o = ~busy_q;
  assign uart_tx_o  = frame_q[0];

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      busy_q    <= 1'b0;
      div_cnt_q <= '0;
      bit_idx_q <= '0;
      frame_q   <= '1;
    end else if (!busy_q) begin
      if (tx_valid_i) begin
        busy_q    <= 1'b1;
        div_cnt_q <= '0;
        bit_idx_q <= '0;
        frame_q   <= {1'b1, tx_byte_i, 1'b0};
      end
    end else begin
      if (div_cnt_q == DIV_W'(`SOC_UART_DIV - 1)) begin
        div_cnt_q <= '0;
        bit_idx_q <= bit_idx_q + 1'b1;
        // shift in ones so the line idles high afterwards
        frame_q   <= {1'b1, frame_q[9:1]};
        if (bit_idx_q == 4'd9) begin
          busy_q <= 1'b0;
        end
      end else begin
        div_cnt_q <= div_cnt_q + 1'b1;
      end
    end
  end

endmodule

//--- source/uart_rx_monitor.sv
// uart receive monitor
// 8N1 receiver on the transmit line, samples mid-bit and
// strobes each good byte for one cycle

`timescale 1ns/1ps

`include "soc_defines.svh"

module uart_rx_monitor (
  input  logic       clk_i,
  input  logic       rst_n_i,
  input  logic       uart_rx_i,
  output logic       data_valid_o,
  output logic [7:0] data_o
);

  localparam int DIV_W = $clog2(`SOC_UART_DIV);

  logic             rx_prev_q;
  logic             active_q;
  logic [DIV_W-1:0] cnt_q;
  // 0 start, 1..8 data, 9 stop
  logic [3:0]       bit_idx_q;
  logic [7:0]       shift_q;
  logic             valid_q;
  logic [7:0]       data_q;

  assign data_valid_o = valid_q;
  assign data_o       = data_q;

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      rx_prev_q <= 1'b1;
      active_q  <= 1'b0;
      cnt_q     <= '0;
      bit_idx_q <= '0;
      valid_q   <= 1'b0;
    end else begin
      rx_prev_q <= uart_rx_i;
      valid_q   <= 1'b0;
      if (!active_q) begin
        // falling edge starts a frame, first sample half a bit in
        if (rx_prev_q && !uart_rx_i) begin
          active_q  <= 1'b1;
          cnt_q     <= DIV_W'(`SOC_UART_DIV / 2 - 1);
          bit_idx_q <= '0;
        end
      end else if (cnt_q != '0) begin
        cnt_q <= cnt_q - 1'b1;
      end else begin
        cnt_q     <= DIV_W'(`SOC_UART_DIV - 1);
        bit_idx_q <= bit_idx_q + 1'b1;
        if (bit_idx_q == 4'd0 && uart_rx_i) begin
          // glitch, not a real start bit
          active_q <= 1'b0;
        end else if (bit_idx_q == 4'd9) begin
          active_q <= 1'b0;
          // bad stop bit drops the byte
          valid_q  <= uart_rx_i;
        end
      end
    end
  end

  // data path
  always_ff @(posedge clk_i) begin
    if (active_q && cnt_q == '0) begin
      if (bit_idx_q >= 4'd1 && bit_idx_q <= 4'd8) begin
        shift_q <= {uart_rx_i, shift_q[7:1]};
      end
      if (bit_idx_q == 4'd9) begin
        data_q <= shift_q;
      end
    end
  end

endmodule

//--- source/soc_wrapper.sv
// soc slice top level
// host port and console DMA share one SRAM through the arbiter,
// console bytes leave on the UART line and are looped into the rx monitor

`timescale 1ns/1ps

`include "soc_defines.svh"

module soc_wrapper (
  input  logic                   clk_i,
  input  logic                   rst_n_i,

  // host memory port
  input  logic                   host_req_i,
  input  logic [`SOC_ADDR_W-1:0] host_addr_i,
  input  logic                   host_we_i,
  input  logic [`SOC_DATA_W-1:0] host_wdata_i,
  input  logic [`SOC_BE_W-1:0]   host_be_i,
  output logic                   host_gnt_o,
  output logic                   host_rsp_valid_o,
  output logic [`SOC_DATA_W-1:0] host_rdata_o,

  // console
  input  logic                   console_start_i,
  input  logic [`SOC_ADDR_W-1:0] console_base_i,
  input  logic [`SOC_LEN_W-1:0]  console_len_i,
  output logic                   console_busy_o,

  // UART
  output logic                   uart_tx_o,
  output logic                   uart_data_valid_o,
  output logic [7:0]             uart_data_o
);

  import soc_pkg::*;

  mem_req_t     host_pkt;
  mem_rsp_t     host_rsp;
  mem_req_t     con_pkt;
  mem_rsp_t     con_rsp;
  logic         con_req;
  logic         con_gnt;
  logic         con_rsp_valid;
  mem_req_t     sram_pkt;
  mem_rsp_t     sram_rsp;
  logic         sram_en;
  console_cmd_t con_cmd;
  logic         tx_valid;
  logic [7:0]   tx_byte;
  logic         tx_ready;
  logic         uart_line;

  assign host_pkt     = '{addr: host_addr_i, we: host_we_i, wdata: host_wdata_i, be: host_be_i};
  assign host_rdata_o = host_rsp.rdata;
  assign con_cmd      = '{base: console_base_i, len: console_len_i};
  assign uart_tx_o    = uart_line;

  //////////////////////////////
  // memory path
  //////////////////////////////

  mem_arbiter u_mem_arbiter (
    .clk_i          ( clk_i            ),
    .rst_n_i        ( rst_n_i          ),
    .m0_req_i       ( host_req_i       ),
    .m0_pkt_i       ( host_pkt         ),
    .m0_gnt_o       ( host_gnt_o       ),
    .m0_rsp_valid_o ( host_rsp_valid_o ),
    .m0_rsp_o       ( host_rsp         ),
    .m1_req_i       ( con_req          ),
    .m1_pkt_i       ( con_pkt          ),
    .m1_gnt_o       ( con_gnt          ),
    .m1_rsp_valid_o ( con_rsp_valid    ),
    .m1_rsp_o       ( con_rsp          ),
    .mem_en_o       ( sram_en          ),
    .mem_pkt_o      ( sram_pkt         ),
    .mem_rsp_i      ( sram_rsp         )
  );

  sram_bank u_sram_bank (
    .clk_i     ( clk_i    ),
    .mem_en_i  ( sram_en  ),
    .mem_pkt_i ( sram_pkt ),
    .mem_rsp_o ( sram_rsp )
  );

  //////////////////////////////
  // console and UART
  //////////////////////////////

  console_dma u_console_dma (
    .clk_i       ( clk_i           ),
    .rst_n_i     ( rst_n_i         ),
    .start_i     ( console_start_i ),
    .cmd_i       ( con_cmd         ),
    .busy_o      ( console_busy_o  ),
    .req_o       ( con_req         ),
    .pkt_o       ( con_pkt         ),
    .gnt_i       ( con_gnt         ),
    .rsp_valid_i ( con_rsp_valid   ),
    .rsp_i       ( con_rsp         ),
    .tx_valid_o  ( tx_valid        ),
    .tx_byte_o   ( tx_byte         ),
    .tx_ready_i  ( tx_ready        )
  );

  uart_tx u_uart_tx (
    .clk_i      ( clk_i     ),
    .rst_n_i    ( rst_n_i   ),
    .tx_valid_i ( tx_valid  ),
    .tx_byte_i  ( tx_byte   ),
    .tx_ready_o ( tx_ready  ),
    .uart_tx_o  ( uart_line )
  );

  // monitor listens on our own transmit line
  uart_rx_monitor u_uart_rx_monitor (
    .clk_i        ( clk_i             ),
    .rst_n_i      ( rst_n_i           ),
    .uart_rx_i    ( uart_line         ),
    .data_valid_o ( uart_data_valid_o ),
    .data_o       ( uart_data_o       )
  );

endmodule

//--- bench/tb_soc_wrapper.sv
// soc slice testbench
// host traffic against a memory model, console print jobs checked
// byte by byte on the monitor strobe, all under a watchdog

`timescale 1ns/1ps

`include "soc_defines.svh"

module tb_soc_wrapper;

  localparam int CLK_PERIOD  = 20;
  localparam int MAX_JOB_LEN = 48;
  localparam int NUM_RAND    = 16;
  localparam int NUM_LOAD    = 40;
  // four jobs worst case, every host access, and some slack
  localparam int HOST_OPS    = `SOC_MEM_WORDS + 2 * NUM_RAND + 2 * NUM_LOAD;
  localparam int TIMEOUT_CYC = 4 * MAX_JOB_LEN * 10 * `SOC_UART_DIV + HOST_OPS * 8 + 2000;

  logic                   clk_i;
  logic                   rst_n_i;
  logic                   host_req_i;
  logic [`SOC_ADDR_W-1:0] host_addr_i;
  logic                   host_we_i;
  logic [`SOC_DATA_W-1:0] host_wdata_i;
  logic [`SOC_BE_W-1:0]   host_be_i;
  logic                   host_gnt_o;
  logic                   host_rsp_valid_o;
  logic [`SOC_DATA_W-1:0] host_rdata_o;
  logic                   console_start_i;
  logic [`SOC_ADDR_W-1:0] console_base_i;
  logic [`SOC_LEN_W-1:0]  console_len_i;
  logic                   console_busy_o;
  logic                   uart_tx_o;
  logic                   uart_data_valid_o;
  logic [7:0]             uart_data_o;

  // mirror of the SRAM, kept by the host writes
  logic [`SOC_DATA_W-1:0] mem_model [`SOC_MEM_WORDS];
  logic [31:0]            rng_state;
  logic [`SOC_ADDR_W-1:0] job_base;
  int                     job_len;
  int                     rx_count;

  soc_wrapper u_soc_wrapper (
    .clk_i             ( clk_i             ),
    .rst_n_i           ( rst_n_i           ),
    .host_req_i        ( host_req_i        ),
    .host_addr_i       ( host_addr_i       ),
    .host_we_i         ( host_we_i         ),
    .host_wdata_i      ( host_wdata_i      ),
    .host_be_i         ( host_be_i         ),
    .host_gnt_o        ( host_gnt_o        ),
    .host_rsp_valid_o  ( host_rsp_valid_o  ),
    .host_rdata_o      ( host_rdata_o      ),
    .console_start_i   ( console_start_i   ),
    .console_base_i    ( console_base_i    ),
    .console_len_i     ( console_len_i     ),
    .console_busy_o    ( console_busy_o    ),
    .uart_tx_o         ( uart_tx_o         ),
    .uart_data_valid_o ( uart_data_valid_o ),
    .uart_data_o       ( uart_data_o       )
  );

  initial begin
    clk_i = 1'b0;
    forever #(CLK_PERIOD / 2) clk_i = ~clk_i;
  end

  //////////////////////////////
  // helpers
  //////////////////////////////

  function automatic logic [31:0] next_random();
    rng_state = rng_state ^ (rng_state << 13);
    rng_state = rng_state ^ (rng_state >> 17);
    rng_state = rng_state ^ (rng_state << 5);
    return rng_state;
  endfunction

  // byte idx of a print job, lowest byte of the base word first
  function automatic logic [7:0] expected_byte(input logic [7:0] base, input int len,
                                               input int idx);
    logic [7:0]  word_addr;
    logic [31:0] word;
    if (idx >= len) begin
      return 8'h00;
    end
    word_addr = base + 8'(idx / 4);
    word      = mem_model[word_addr];
    return word[8 * (idx % 4) +: 8];
  endfunction

  task automatic fail_run(input string why);
    $display("%s", why);
    $display("TB FAILED");
    $fatal(1);
  endtask

  task automatic check_value(input string name, input logic [31:0] actual,
                             input logic [31:0] expected);
    if (actual !== expected) begin
      fail_run($sformatf("FAILED %s: got 0x%0h expected 0x%0h", name, actual, expected));
    end
  endtask

  // one host access, grant within two cycles, response one cycle later
  task automatic host_access(input logic [7:0] addr, input logic we,
                             input logic [31:0] wdata, input logic [3:0] be);
    int          waited;
    logic [31:0] exp;
    @(posedge clk_i);
    #2;
    host_req_i   = 1'b1;
    host_addr_i  = addr;
    host_we_i    = we;
    host_wdata_i = wdata;
    host_be_i    = be;
    waited       = 0;
    @(negedge clk_i);
    while (!host_gnt_o) begin
      check_value("host_rsp_valid_o", host_rsp_valid_o, 1'b0);
      waited++;
      if (waited >= 2) begin
        fail_run("host request was not granted within two cycles");
      end
      @(negedge clk_i);
    end
    if (we) begin
      for (int i = 0; i < `SOC_BE_W; i++) begin
        if (be[i]) begin
          mem_model[addr][i*8 +: 8] = wdata[i*8 +: 8];
        end
      end
    end
    exp = mem_model[addr];
    @(posedge clk_i);
    #2;
    host_req_i = 1'b0;
    @(negedge clk_i);
    check_value("host_rsp_valid_o", host_rsp_valid_o, 1'b1);
    if (!we) begin
      check_value("host_rdata_o", host_rdata_o, exp);
    end
  endtask

  task automatic pulse_start(input logic [7:0] base, input int len);
    @(posedge clk_i);
    #2;
    console_start_i = 1'b1;
    console_base_i  = base;
    console_len_i   = `SOC_LEN_W'(len);
    @(posedge clk_i);
    #2;
    console_start_i = 1'b0;
  endtask

  task automatic start_job(input logic [7:0] base, input int len);
    job_base = base;
    job_len  = len;
    rx_count = 0;
    pulse_start(base, len);
    @(negedge clk_i);
    check_value("console_busy_o", console_busy_o, 1'b1);
  endtask

  task automatic wait_job_done();
    while (console_busy_o) begin
      @(negedge clk_i);
    end
    check_value("uart byte count", rx_count, job_len);
  endtask

  // read-after-write traffic in the upper half, away from any print job,
  // kept going until the print is over so the console fetches meet it
  task automatic host_load(input int count);
    logic [31:0] r;
    logic [7:0]  addr;
    for (int n = 0; n < count || console_busy_o; n++) begin
      r    = next_random();
      addr = {1'b1, r[6:0]};
      host_access(addr, 1'b1, next_random(), r[11:8]);
      host_access(addr, 1'b0, '0, '0);
    end
  endtask

  //////////////////////////////
  // comparator
  //////////////////////////////

  always @(negedge clk_i) begin
    if (rst_n_i && uart_data_valid_o) begin
      if (rx_count >= job_len) begin
        fail_run("uart byte arrived with no byte left in the print job");
      end else begin
        check_value("uart_data_o", uart_data_o, expected_byte(job_base, job_len, rx_count));
        rx_count++;
      end
    end
  end

  initial begin
    #(TIMEOUT_CYC * CLK_PERIOD);
    fail_run("timeout, the tests did not finish in the expected time");
  end

  //////////////////////////////
  // main sequence
  //////////////////////////////

  initial begin
    logic [7:0]  addrs [NUM_RAND];
    logic [31:0] r;
    rng_state       = 32'd26328;
    rst_n_i         = 1'b0;
    host_req_i      = 1'b0;
    host_addr_i     = '0;
    host_we_i       = 1'b0;
    host_wdata_i    = '0;
    host_be_i       = '0;
    console_start_i = 1'b0;
    console_base_i  = '0;
    console_len_i   = '0;
    job_base        = '0;
    job_len         = 0;
    rx_count        = 0;

    // reset state
    repeat (2) @(posedge clk_i);
    #2;
    rst_n_i = 1'b1;
    @(negedge clk_i);
    check_value("host_gnt_o", host_gnt_o, 1'b0);
    check_value("host_rsp_valid_o", host_rsp_valid_o, 1'b0);
    check_value("console_busy_o", console_busy_o, 1'b0);
    check_value("uart_data_valid_o", uart_data_valid_o, 1'b0);
    check_value("uart_tx_o", uart_tx_o, 1'b1);

    // fill every word so nothing reads back unknown
    for (int a = 0; a < `SOC_MEM_WORDS; a++) begin
      host_access(8'(a), 1'b1, next_random(), 4'hf);
    end

    // partial writes, then read them all back
    for (int n = 0; n < NUM_RAND; n++) begin
      r        = next_random();
      addrs[n] = r[7:0];
      host_access(addrs[n], 1'b1, next_random(), r[11:8]);
    end
    for (int n = 0; n < NUM_RAND; n++) begin
      host_access(addrs[n], 1'b0, '0, '0);
    end

    // plain print job
    r = next_random();
    start_job(8'(r[5:0]), 1 + int'(r[15:8]) % MAX_JOB_LEN);
    wait_job_done();

    // host traffic while the console prints
    r = next_random();
    fork
      begin
        start_job(8'(r[5:0]), 1 + int'(r[15:8]) % MAX_JOB_LEN);
        wait_job_done();
      end
      host_load(NUM_LOAD);
    join

    // second start during a print is dropped
    r = next_random();
    start_job(8'(r[5:0]), 1 + int'(r[15:8]) % MAX_JOB_LEN);
    repeat (40) @(negedge clk_i);
    pulse_start(8'h20, 7);
    @(negedge clk_i);
    wait_job_done();

    // empty job, one busy cycle and no strobe
    start_job(8'h10, 0);
    @(negedge clk_i);
    check_value("console_busy_o", console_busy_o, 1'b0);
    repeat (2 * 10 * `SOC_UART_DIV) @(negedge clk_i);
    check_value("uart byte count", rx_count, 0);

    $display("TB PASSED");
    $finish;
  end

endmodule

//--- tb.f
+incdir+source
source/soc_pkg.sv
source/mem_arbiter.sv
source/sram_bank.sv
source/console_dma.sv
source/uart_tx.sv
source/uart_rx_monitor.sv
source/soc_wrapper.sv
bench/tb_soc_wrapper.sv
